// File: src.f
+incdir+include
rtl/exe_pkg.sv
rtl/exe_operand_stage.sv
rtl/exe_alu.sv
rtl/exe_branch_jump.sv
rtl/exe_unit.sv
bench/exe_unit_asserts.sv
bench/exe_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module exe_unit_tb

status=0
output=$(./obj_dir/Vexe_unit_tb 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
        echo "simulation passed"
        exit 0
fi
echo "simulation failed (exit status $status)"
exit 1

// File: bench/exe_unit_tb.sv
`timescale 1ns/1ps

`include "exe_consts.svh"

module exe_unit_tb;

        import exe_pkg::*;

        localparam int          TIMEOUT   = 20;

        // ctl bit order: lui auipc jal jalr branch imm_y save_to_rd
        localparam exe_ctl_t    CTL_OP    = 7'b000_0001;
        localparam exe_ctl_t    CTL_IMM   = 7'b000_0011;
        localparam exe_ctl_t    CTL_LUI   = 7'b100_0001;
        localparam exe_ctl_t    CTL_AUIPC = 7'b010_0001;
        localparam exe_ctl_t    CTL_JAL   = 7'b001_0001;
        localparam exe_ctl_t    CTL_JALR  = 7'b000_1011;
        localparam exe_ctl_t    CTL_BR    = 7'b000_0100;

        // which outputs an entry compares
        localparam logic [4:0]  M_DATA    = 5'b00001;
        localparam logic [4:0]  M_RD      = 5'b00010;
        localparam logic [4:0]  M_BR      = 5'b00100;
        localparam logic [4:0]  M_JAL     = 5'b01000;
        localparam logic [4:0]  M_JALR    = 5'b10000;

        typedef struct packed {
                instr_t         instr;
                pc_t            pc;
                word_t          rs1;
                word_t          rs2;
                exe_ctl_t       ctl;
                word_t          data;
                reg_addr_t      rd;
                logic           taken;
                pc_t            baddr;
                pc_t            jaddr;
                pc_t            jraddr;
                logic [4:0]     mask;
        } vector_t;

        logic           clk;
        logic           reset_n;
        logic           exe_enable_i;
        instr_t         instr_i;
        pc_t            pc_i;
        word_t          rs1_i;
        word_t          rs2_i;
        exe_ctl_t       ctl_i;
        logic           valid_o;
        word_t          data_o;
        reg_addr_t      rd_addr_o;
        logic           save_to_rd_o;
        logic           branch_taken_o;
        pc_t            branch_addr_o;
        logic           jal_active_o;
        pc_t            jal_addr_o;
        logic           jalr_active_o;
        pc_t            jalr_addr_o;

        vector_t        vectors[$];
        string          names[$];

        exe_unit exe_unit_i (.*);

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        // --------------------------------------------------
        // instruction encoders, rs1 = x1 and rs2 = x2
        // --------------------------------------------------
        function automatic instr_t r_type(input logic [6:0] f7, input funct3_t f3,
                                          input reg_addr_t rd);
                return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
        endfunction

        function automatic instr_t i_type(input logic [11:0] imm, input funct3_t f3,
                                          input reg_addr_t rd);
                return {imm, 5'd1, f3, rd, 7'b0010011};
        endfunction

        function automatic instr_t j_type(input logic [20:0] off, input reg_addr_t rd);
                return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
        endfunction

        // --------------------------------------------------
        // table construction
        // --------------------------------------------------
        task automatic add_vector(input string name, input vector_t v);
                names.push_back(name);
                vectors.push_back(v);
        endtask

        task automatic add_alu(input string name, input instr_t instr, input reg_addr_t rd,
                               input word_t rs1, input word_t rs2, input word_t result);
                exe_ctl_t ctl;
                // OP has opcode bit 5 set, OP-IMM does not
                ctl = instr[5] ? CTL_OP : CTL_IMM;
                add_vector(name, vector_t'{instr, 32'h100, rs1, rs2, ctl, result, rd, 1'b0,
                                           32'h0, 32'h0, 32'h0, M_DATA | M_RD});
        endtask

        task automatic add_branch(input string name, input funct3_t f3, input logic [12:0] off,
                                  input word_t rs1, input word_t rs2, input logic taken,
                                  input pc_t target);
                instr_t instr;
                instr = {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
                add_vector(name, vector_t'{instr, 32'h2000, rs1, rs2, CTL_BR, 32'h0, 5'd0, taken,
                                           target, 32'h0, 32'h0, M_BR});
        endtask

        task automatic build_table();
                add_alu("add", r_type(7'h00, `EXE_ALU_ADD_SUB, 5'd5), 5'd5, 32'h1234, 32'h0f0f,
                        32'h2143);
                add_alu("sub", r_type(7'h20, `EXE_ALU_ADD_SUB, 5'd6), 5'd6, 32'h10, 32'h30,
                        32'hffffffe0);
                add_alu("addi_neg", i_type(12'hffb, `EXE_ALU_ADD_SUB, 5'd7), 5'd7, 32'h100,
                        32'h0, 32'hfb);
                add_alu("sll", r_type(7'h00, `EXE_ALU_SLL, 5'd8), 5'd8, 32'h1, 32'h24, 32'h10);
                add_alu("slt", r_type(7'h00, `EXE_ALU_SLT, 5'd9), 5'd9, 32'hffffffff, 32'h1,
                        32'h1);
                add_alu("sltu", r_type(7'h00, `EXE_ALU_SLTU, 5'd10), 5'd10, 32'hffffffff, 32'h1,
                        32'h0);
                add_alu("xori", i_type(12'h0ff, `EXE_ALU_XOR, 5'd11), 5'd11, 32'h0f0f0f0f, 32'h0,
                        32'h0f0f0ff0);
                add_alu("srl", r_type(7'h00, `EXE_ALU_SRL_SRA, 5'd12), 5'd12, 32'h80000000, 32'h4,
                        32'h08000000);
                add_alu("sra", r_type(7'h20, `EXE_ALU_SRL_SRA, 5'd13), 5'd13, 32'h80000000, 32'h4,
                        32'hf8000000);
                add_alu("srai", i_type(12'h402, `EXE_ALU_SRL_SRA, 5'd14), 5'd14, 32'hf00000f0,
                        32'h0, 32'hfc00003c);
                add_alu("or", r_type(7'h00, `EXE_ALU_OR, 5'd15), 5'd15, 32'h00ff0000, 32'h0000ff00,
                        32'h00ffff00);
                add_alu("andi", i_type(12'hff0, `EXE_ALU_AND, 5'd16), 5'd16, 32'h12345678, 32'h0,
                        32'h12345670);
                add_alu("slti_neg", i_type(12'hfff, `EXE_ALU_SLT, 5'd17), 5'd17, 32'h5, 32'h0,
                        32'h0);
                add_alu("sltiu_neg", i_type(12'hfff, `EXE_ALU_SLTU, 5'd18), 5'd18, 32'h5, 32'h0,
                        32'h1);

                add_vector("lui", vector_t'{{20'habcde, 5'd19, 7'b0110111}, 32'h100, 32'h0, 32'h0,
                           CTL_LUI, 32'habcde000, 5'd19, 1'b0, 32'h0, 32'h0, 32'h0,
                           M_DATA | M_RD});
                add_vector("auipc", vector_t'{{20'h00012, 5'd20, 7'b0010111}, 32'h1000, 32'h0,
                           32'h0, CTL_AUIPC, 32'h13000, 5'd20, 1'b0, 32'h0, 32'h0, 32'h0,
                           M_DATA | M_RD});
                add_vector("auipc_neg", vector_t'{{20'hfffff, 5'd21, 7'b0010111}, 32'h2000, 32'h0,
                           32'h0, CTL_AUIPC, 32'h1000, 5'd21, 1'b0, 32'h0, 32'h0, 32'h0,
                           M_DATA | M_RD});

                add_branch("beq_t", `EXE_BR_BEQ, 13'h0010, 32'd7, 32'd7, 1'b1, 32'h2010);
                add_branch("beq_n", `EXE_BR_BEQ, 13'h0010, 32'd7, 32'd8, 1'b0, 32'h2010);
                add_branch("bne_t", `EXE_BR_BNE, 13'h1ff8, 32'd7, 32'd8, 1'b1, 32'h1ff8);
                add_branch("bne_n", `EXE_BR_BNE, 13'h1ff8, 32'd7, 32'd7, 1'b0, 32'h1ff8);
                add_branch("blt_t", `EXE_BR_BLT, 13'h0100, 32'hfffffff0, 32'h1, 1'b1, 32'h2100);
                add_branch("blt_n", `EXE_BR_BLT, 13'h0100, 32'h1, 32'hfffffff0, 1'b0, 32'h2100);
                add_branch("bge_t", `EXE_BR_BGE, 13'h1800, 32'h1, 32'hfffffff0, 1'b1, 32'h1800);
                add_branch("bge_n", `EXE_BR_BGE, 13'h1800, 32'hfffffff0, 32'h1, 1'b0, 32'h1800);
                add_branch("bltu_t", `EXE_BR_BLTU, 13'h0ffe, 32'h1, 32'hfffffff0, 1'b1, 32'h2ffe);
                add_branch("bltu_n", `EXE_BR_BLTU, 13'h0ffe, 32'hfffffff0, 32'h1, 1'b0, 32'h2ffe);
                add_branch("bgeu_t", `EXE_BR_BGEU, 13'h1000, 32'hfffffff0, 32'h1, 1'b1, 32'h1000);
                add_branch("bgeu_n", `EXE_BR_BGEU, 13'h1000, 32'h1, 32'hfffffff0, 1'b0, 32'h1000);

                add_vector("jal_fwd", vector_t'{j_type(21'h012344, 5'd1), 32'h4000, 32'h0, 32'h0,
                           CTL_JAL, 32'h4004, 5'd1, 1'b0, 32'h0, 32'h16344, 32'h0,
                           M_DATA | M_RD | M_JAL});
                add_vector("jal_back", vector_t'{j_type(21'h1ffff0, 5'd1), 32'h8000, 32'h0, 32'h0,
                           CTL_JAL, 32'h8004, 5'd1, 1'b0, 32'h0, 32'h7ff0, 32'h0,
                           M_DATA | M_RD | M_JAL});
                // odd sums, bit 0 must be dropped
                add_vector("jalr_odd", vector_t'{{12'h020, 5'd1, 3'b000, 5'd1, 7'b1100111},
                           32'h5000, 32'h1001, 32'h0, CTL_JALR, 32'h5004, 5'd1, 1'b0, 32'h0, 32'h0,
                           32'h1020, M_DATA | M_RD | M_JALR});
                add_vector("jalr_neg", vector_t'{{12'hffd, 5'd1, 3'b000, 5'd1, 7'b1100111},
                           32'h6000, 32'h3000, 32'h0, CTL_JALR, 32'h6004, 5'd1, 1'b0, 32'h0, 32'h0,
                           32'h2ffc, M_DATA | M_RD | M_JALR});
        endtask

        // --------------------------------------------------
        // checking
        // --------------------------------------------------
        task automatic check_value(input string name, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
                if (expected !== actual) begin
                        $display("ERROR %s %s: expected %h, actual %h",
                                 name, field, expected, actual);
                        $display("Finished with errors");
                        $fatal(1, "output mismatch");
                end
        endtask

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("Finished with errors");
                $fatal(1, "run aborted");
        endtask

        task automatic wait_valid(input string name, input logic level);
                int cycles;
                cycles = 0;
                do begin
                        @(posedge clk);
                        #1;
                        cycles++;
                end while (valid_o !== level && cycles < TIMEOUT);
                if (valid_o !== level) begin
                        abort_run($sformatf("timeout: valid_o never became %0b in %s", level, name));
                end
                check_value(name, "latency", 32'd1, cycles);
        endtask

        task automatic check_idle(input string name);
                check_value(name, "valid", 32'd0, {31'd0, valid_o});
                check_value(name, "save_to_rd", 32'd0, {31'd0, save_to_rd_o});
                check_value(name, "branch_taken", 32'd0, {31'd0, branch_taken_o});
                check_value(name, "jal_active", 32'd0, {31'd0, jal_active_o});
                check_value(name, "jalr_active", 32'd0, {31'd0, jalr_active_o});
        endtask

        task automatic check_outputs(input string name, input vector_t v);
                check_value(name, "save_to_rd", {31'd0, v.ctl.save_to_rd}, {31'd0, save_to_rd_o});
                check_value(name, "jal_active", {31'd0, v.ctl.jal}, {31'd0, jal_active_o});
                check_value(name, "jalr_active", {31'd0, v.ctl.jalr}, {31'd0, jalr_active_o});
                check_value(name, "branch_taken", {31'd0, v.taken}, {31'd0, branch_taken_o});
                if (v.mask & M_DATA) begin
                        check_value(name, "data", v.data, data_o);
                end
                if (v.mask & M_RD) begin
                        check_value(name, "rd_addr", {27'd0, v.rd}, {27'd0, rd_addr_o});
                end
                if (v.mask & M_BR) begin
                        check_value(name, "branch_addr", v.baddr, branch_addr_o);
                end
                if (v.mask & M_JAL) begin
                        check_value(name, "jal_addr", v.jaddr, jal_addr_o);
                end
                if (v.mask & M_JALR) begin
                        check_value(name, "jalr_addr", v.jraddr, jalr_addr_o);
                end
        endtask

        task automatic drive_vector(input vector_t v);
                exe_enable_i = 1'b1;
                instr_i      = v.instr;
                pc_i         = v.pc;
                rs1_i        = v.rs1;
                rs2_i        = v.rs2;
                ctl_i        = v.ctl;
        endtask

        // --------------------------------------------------
        // main sequence
        // --------------------------------------------------
        initial begin
                vector_t v;
                reset_n      = 1'b0;
                exe_enable_i = 1'b0;
                instr_i      = '0;
                pc_i         = '0;
                rs1_i        = '0;
                rs2_i        = '0;
                ctl_i        = '0;
                build_table();

                for (int n = 0; n < 5; n++) begin
                        @(posedge clk);
                end
                #1;
                reset_n = 1'b1;
                wait_valid("reset", 1'b0);
                check_idle("reset");

                for (int i = 0; i < vectors.size(); i++) begin
                        v = vectors[i];
                        drive_vector(v);
                        wait_valid(names[i], 1'b1);
                        check_outputs(names[i], v);
                        // idle slot with every flag raised, none may get through
                        if (i % 4 == 3) begin
                                exe_enable_i = 1'b0;
                                ctl_i        = '1;
                                wait_valid({names[i], "_idle"}, 1'b0);
                                check_idle({names[i], "_idle"});
                        end
                end

                $display("Finished with no errors");
                $finish;
        end

endmodule

// File: bench/exe_unit_asserts.sv
`timescale 1ns/1ps

module exe_unit_asserts (
        input  logic            clk,
        input  logic            reset_n,
        input  logic            exe_enable_i,
        input  logic            valid_i,
        input  logic            save_to_rd_i,
        input  logic            branch_taken_i,
        input  logic            jal_active_i,
        input  logic            jalr_active_i,
        input  exe_pkg::pc_t    jalr_addr_i
);

        logic   any_active;

        assign any_active = valid_i | save_to_rd_i | branch_taken_i | jal_active_i |
                            jalr_active_i;

        // --------------------------------------------------
        // one-cycle stage timing
        // --------------------------------------------------
        valid_after_enable: assert property (
                @(posedge clk) disable iff (!reset_n) exe_enable_i |=> valid_i)
                else $error("valid_o missing one cycle after exe_enable_i");

        // an empty slot carries no flags
        quiet_after_idle: assert property (
                @(posedge clk) disable iff (!reset_n) !exe_enable_i |=> !any_active)
                else $error("control flag high in the cycle after an idle edge");

        // jalr target always has bit 0 cleared
        jalr_aligned: assert property (
                @(posedge clk) disable iff (!reset_n) jalr_addr_i[0] == 1'b0)
                else $error("jalr_addr_o has bit 0 set");

endmodule

bind exe_unit exe_unit_asserts exe_unit_asserts_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .exe_enable_i   (exe_enable_i),
        .valid_i        (valid_o),
        .save_to_rd_i   (save_to_rd_o),
        .branch_taken_i (branch_taken_o),
        .jal_active_i   (jal_active_o),
        .jalr_active_i  (jalr_active_o),
        .jalr_addr_i    (jalr_addr_o)
);

// File: rtl/exe_unit.sv
`timescale 1ns/1ps

module exe_unit (
        input  logic                    clk,
        input  logic                    reset_n,

        // decoded instruction in
        input  logic                    exe_enable_i,
        input  exe_pkg::instr_t         instr_i,
        input  exe_pkg::pc_t            pc_i,
        input  exe_pkg::word_t          rs1_i,
        input  exe_pkg::word_t          rs2_i,
        input  exe_pkg::exe_ctl_t       ctl_i,

        // write-back
        output logic                    valid_o,
        output exe_pkg::word_t          data_o,
        output exe_pkg::reg_addr_t      rd_addr_o,
        output logic                    save_to_rd_o,

        // control transfer
        output logic                    branch_taken_o,
        output exe_pkg::pc_t            branch_addr_o,
        output logic                    jal_active_o,
        output exe_pkg::pc_t            jal_addr_o,
        output logic                    jalr_active_o,
        output exe_pkg::pc_t            jalr_addr_o
);

        import exe_pkg::*;

        exe_operands_t  operands;
        exe_stage_t     stage;

        // --------------------------------------------------
        // input register
        // --------------------------------------------------
        exe_operand_stage exe_operand_stage_i (
                .clk            (clk),
                .reset_n        (reset_n),
                .exe_enable_i   (exe_enable_i),
                .instr_i        (instr_i),
                .pc_i           (pc_i),
                .rs1_i          (rs1_i),
                .rs2_i          (rs2_i),
                .ctl_i          (ctl_i),
                .operands_o     (operands),
                .stage_o        (stage)
        );

        // result path
        exe_alu exe_alu_i (
                .operands_i     (operands),
                .stage_i        (stage),
                .data_o         (data_o),
                .rd_addr_o      (rd_addr_o),
                .save_to_rd_o   (save_to_rd_o),
                .valid_o        (valid_o)
        );

        // branch and jump path, targets taken straight from the inputs
        exe_branch_jump exe_branch_jump_i (
                .clk            (clk),
                .reset_n        (reset_n),
                .exe_enable_i   (exe_enable_i),
                .instr_i        (instr_i),
                .pc_i           (pc_i),
                .operands_i     (operands),
                .stage_i        (stage),
                .branch_taken_o (branch_taken_o),
                .branch_addr_o  (branch_addr_o),
                .jal_active_o   (jal_active_o),
                .jal_addr_o     (jal_addr_o),
                .jalr_active_o  (jalr_active_o),
                .jalr_addr_o    (jalr_addr_o)
        );

endmodule

// File: rtl/exe_branch_jump.sv
`timescale 1ns/1ps

`include "exe_consts.svh"

module exe_branch_jump (
        input  logic                    clk,
        input  logic                    reset_n,
        input  logic                    exe_enable_i,
        input  exe_pkg::instr_t         instr_i,
        input  exe_pkg::pc_t            pc_i,
        input  exe_pkg::exe_operands_t  operands_i,
        input  exe_pkg::exe_stage_t     stage_i,
        output logic                    branch_taken_o,
        output exe_pkg::pc_t            branch_addr_o,
        output logic                    jal_active_o,
        output exe_pkg::pc_t            jal_addr_o,
        output logic                    jalr_active_o,
        output exe_pkg::pc_t            jalr_addr_o
);

        import exe_pkg::*;

        word_t          b_offset;
        word_t          j_offset;
        word_t          i_offset;
        word_t          jalr_sum;
        pc_t            branch_addr_q;
        pc_t            jal_addr_q;
        logic           x_eq_y;
        logic           x_lt_y;
        logic           x_ltu_y;
        logic           cond;

        // --------------------------------------------------
        // targets from the incoming instruction
        // --------------------------------------------------
        assign b_offset = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                           instr_i[11:8], 1'b0};
        assign j_offset = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                           instr_i[30:21], 1'b0};

        always_ff @(posedge clk or negedge reset_n) begin
                if (!reset_n) begin
                        branch_addr_q <= '0;
                        jal_addr_q    <= '0;
                end else if (exe_enable_i) begin
                        branch_addr_q <= pc_i + b_offset;
                        jal_addr_q    <= pc_i + j_offset;
                end
        end

        assign branch_addr_o = branch_addr_q;
        assign jal_addr_o    = jal_addr_q;

        // --------------------------------------------------
        // branch condition on the held operands
        // --------------------------------------------------
        assign x_eq_y  = operands_i.x == operands_i.y;
        assign x_lt_y  = $signed(operands_i.x) < $signed(operands_i.y);
        assign x_ltu_y = operands_i.x < operands_i.y;

        always_comb begin
                case (operands_i.funct3)
                        `EXE_BR_BEQ:  cond = x_eq_y;
                        `EXE_BR_BNE:  cond = ~x_eq_y;
                        `EXE_BR_BLT:  cond = x_lt_y;
                        `EXE_BR_BGE:  cond = ~x_lt_y;
                        `EXE_BR_BLTU: cond = x_ltu_y;
                        `EXE_BR_BGEU: cond = ~x_ltu_y;
                        // 010 and 011 are not branch encodings
                        default:      cond = 1'b0;
                endcase
        end

        assign branch_taken_o = stage_i.ctl.branch & cond;

        // --------------------------------------------------
        // jalr target, bit 0 forced low
        // --------------------------------------------------
        assign i_offset    = {{20{stage_i.instr[31]}}, stage_i.instr[31:20]};
        assign jalr_sum    = operands_i.x + i_offset;
        assign jalr_addr_o = {jalr_sum[`EXE_XLEN-1:1], 1'b0};

        assign jal_active_o  = stage_i.ctl.jal;
        assign jalr_active_o = stage_i.ctl.jalr;

endmodule

// File: rtl/exe_alu.sv
`timescale 1ns/1ps

`include "exe_consts.svh"

module exe_alu (
        input  exe_pkg::exe_operands_t  operands_i,
        input  exe_pkg::exe_stage_t     stage_i,
        output exe_pkg::word_t          data_o,
        output exe_pkg::reg_addr_t      rd_addr_o,
        output logic                    save_to_rd_o,
        output logic                    valid_o
);

        import exe_pkg::*;

        word_t          x;
        word_t          y;
        logic [4:0]     shamt;
        logic           lt_signed;
        logic           lt_unsigned;
        word_t          alu_out;
        word_t          upper_imm;
        word_t          link_value;

        assign x     = operands_i.x;
        assign y     = operands_i.y;
        assign shamt = y[4:0];

        assign lt_signed   = $signed(x) < $signed(y);
        assign lt_unsigned = x < y;

        // --------------------------------------------------
        // integer operations
        // --------------------------------------------------
        always_comb begin
                case (operands_i.funct3)
                        `EXE_ALU_ADD_SUB: begin
                                alu_out = operands_i.sub ? (x - y) : (x + y);
                        end
                        `EXE_ALU_SLL: begin
                                alu_out = x << shamt;
                        end
                        `EXE_ALU_SLT: begin
                                alu_out = word_t'(lt_signed);
                        end
                        `EXE_ALU_SLTU: begin
                                alu_out = word_t'(lt_unsigned);
                        end
                        `EXE_ALU_XOR: begin
                                alu_out = x ^ y;
                        end
                        `EXE_ALU_SRL_SRA: begin
                                // sign bit fills from the left for sra
                                if (operands_i.sra) begin
                                        alu_out = word_t'($signed(x) >>> shamt);
                                end else begin
                                        alu_out = x >> shamt;
                                end
                        end
                        `EXE_ALU_OR: begin
                                alu_out = x | y;
                        end
                        default: begin
                                alu_out = x & y;
                        end
                endcase
        end

        // --------------------------------------------------
        // write-back selection
        // --------------------------------------------------
        assign upper_imm  = {stage_i.instr[31:12], 12'd0};
        assign link_value = stage_i.pc + `EXE_LINK_STEP;

        always_comb begin
                if (stage_i.ctl.lui) begin
                        data_o = upper_imm;
                end else if (stage_i.ctl.jal | stage_i.ctl.jalr) begin
                        data_o = link_value;
                end else begin
                        // auipc arrives here as an add
                        data_o = alu_out;
                end
        end

        assign rd_addr_o    = stage_i.instr[11:7];
        assign save_to_rd_o = stage_i.ctl.save_to_rd;
        assign valid_o      = stage_i.valid;

endmodule

// File: rtl/exe_operand_stage.sv
`timescale 1ns/1ps

`include "exe_consts.svh"

module exe_operand_stage (
        input  logic                    clk,
        input  logic                    reset_n,
        input  logic                    exe_enable_i,
        input  exe_pkg::instr_t         instr_i,
        input  exe_pkg::pc_t            pc_i,
        input  exe_pkg::word_t          rs1_i,
        input  exe_pkg::word_t          rs2_i,
        input  exe_pkg::exe_ctl_t       ctl_i,
        output exe_pkg::exe_operands_t  operands_o,
        output exe_pkg::exe_stage_t     stage_o
);

        import exe_pkg::*;

        word_t          imm_i_ext;
        word_t          imm_u;
        exe_operands_t  operands_d;
        exe_operands_t  operands_q;
        pc_t            pc_q;
        instr_t         instr_q;
        exe_ctl_t       ctl_q;
        logic           valid_q;

        // --------------------------------------------------
        // immediates of the incoming instruction
        // --------------------------------------------------
        assign imm_i_ext = {{20{instr_i[31]}}, instr_i[31:20]};
        assign imm_u     = {instr_i[31:12], 12'd0};

        // --------------------------------------------------
        // operand selection
        // --------------------------------------------------
        always_comb begin
                // auipc adds pc and the upper immediate
                if (ctl_i.auipc) begin
                        operands_d.x      = pc_i;
                        operands_d.y      = imm_u;
                        operands_d.funct3 = `EXE_ALU_ADD_SUB;
                end else begin
                        operands_d.x      = rs1_i;
                        operands_d.funct3 = instr_i[14:12];
                        if (ctl_i.imm_y) begin
                                operands_d.y = imm_i_ext;
                        end else begin
                                operands_d.y = rs2_i;
                        end
                end

                // sub only exists in the register-register encoding
                operands_d.sub = instr_i[5] & instr_i[30] & ~ctl_i.auipc;
                operands_d.sra = instr_i[30];
        end

        // --------------------------------------------------
        // data registers, loaded every cycle
        // --------------------------------------------------
        always_ff @(posedge clk) begin
                operands_q <= operands_d;
                pc_q       <= pc_i;
                instr_q    <= instr_i;
        end

        // control flags only live for one strobed cycle
        always_ff @(posedge clk or negedge reset_n) begin
                if (!reset_n) begin
                        ctl_q   <= '0;
                        valid_q <= 1'b0;
                end else if (exe_enable_i) begin
                        ctl_q   <= ctl_i;
                        valid_q <= 1'b1;
                end else begin
                        ctl_q   <= '0;
                        valid_q <= 1'b0;
                end
        end

        // --------------------------------------------------
        // outputs
        // --------------------------------------------------
        assign operands_o = operands_q;

        always_comb begin
                stage_o.pc    = pc_q;
                stage_o.instr = instr_q;
                stage_o.ctl   = ctl_q;
                stage_o.valid = valid_q;
        end

endmodule

// File: rtl/exe_pkg.sv
`include "exe_consts.svh"

package exe_pkg;

        // --------------------------------------------------
        // basic vectors
        // --------------------------------------------------
        typedef logic [`EXE_XLEN-1:0]   word_t;
        typedef logic [`EXE_XLEN-1:0]   pc_t;
        typedef logic [31:0]            instr_t;
        typedef logic [2:0]             funct3_t;
        typedef logic [4:0]             reg_addr_t;

        // --------------------------------------------------
        // decode flags from the decode stage
        // --------------------------------------------------
        typedef struct packed {
                logic   lui;
                logic   auipc;
                logic   jal;
                logic   jalr;
                logic   branch;
                // y from the 12-bit I immediate
                logic   imm_y;
                logic   save_to_rd;
        } exe_ctl_t;

        // registered ALU / compare operands
        typedef struct packed {
                word_t          x;
                word_t          y;
                funct3_t        funct3;
                // subtract instead of add
                logic           sub;
                // arithmetic right shift
                logic           sra;
        } exe_operands_t;

        // held instruction context for the current stage slot
        typedef struct packed {
                pc_t            pc;
                instr_t         instr;
                exe_ctl_t       ctl;
                logic           valid;
        } exe_stage_t;

endpackage

// File: include/exe_consts.svh
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

// --------------------------------------------------
// data path width
// --------------------------------------------------
`define EXE_XLEN                32

// --------------------------------------------------
// funct3 codes for OP / OP-IMM
// --------------------------------------------------
`define EXE_ALU_ADD_SUB         3'b000
`define EXE_ALU_SLL             3'b001
`define EXE_ALU_SLT             3'b010
`define EXE_ALU_SLTU            3'b011
`define EXE_ALU_XOR             3'b100
`define EXE_ALU_SRL_SRA         3'b101
`define EXE_ALU_OR              3'b110
`define EXE_ALU_AND             3'b111

// --------------------------------------------------
// funct3 codes for conditional branches
// --------------------------------------------------
`define EXE_BR_BEQ              3'b000
`define EXE_BR_BNE              3'b001
`define EXE_BR_BLT              3'b100
`define EXE_BR_BGE              3'b101
`define EXE_BR_BLTU             3'b110
`define EXE_BR_BGEU             3'b111

// return address offset for jal / jalr
`define EXE_LINK_STEP           4

`endif
